// ==== logic/merge_pkg.sv ====
`default_nettype none

package merge_pkg;

    // data path width, one word per handshake
    localparam int WORD_WIDTH = 16;

    // per-channel buffer sizing
    localparam int FIFO_ADDR_WIDTH = 3;
    localparam int FIFO_DEPTH = 1 << FIFO_ADDR_WIDTH;

    // one word as carried from producer to consumer
    typedef logic [WORD_WIDTH-1:0] word_t;

    // channel tag, 0 or 1 names the ingress port
    typedef logic chan_t;

    // merger sequence
    //   IDLE     pick a channel and pop its FIFO
    //   LOAD     pop_data is valid, latch it into the output register
    //   OFFER    out_req high, wait for out_ack
    //   RELEASE  out_req low, wait for out_ack to drop
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        OFFER,
        RELEASE
    } merge_state_t;

endpackage

`default_nettype wire

// ==== logic/fifo_simple.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_simple #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 3
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  push,
    input  logic [DATA_WIDTH-1:0] push_data,

    input  logic                  pop,
    output logic [DATA_WIDTH-1:0] pop_data,

    output logic                  empty,
    output logic                  full,
    output logic                  empty_a,
    output logic                  full_a,
    output logic [ADDR_WIDTH:0]   count
);

    // depth and the almost thresholds, sized to the count width
    localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};
    localparam logic [ADDR_WIDTH:0] ONE = {{ADDR_WIDTH{1'b0}}, 1'b1};
    localparam logic [ADDR_WIDTH:0] DEPTH_A = DEPTH - ONE;

    logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

    // pointers carry one extra wrap bit above the address
    logic [ADDR_WIDTH:0] push_ptr;
    logic [ADDR_WIDTH:0] pop_ptr;
    logic [ADDR_WIDTH:0] push_ptr_nx;
    logic [ADDR_WIDTH:0] pop_ptr_nx;
    logic [ADDR_WIDTH:0] count_nx;

    logic do_push;
    logic do_pop;

    // push while full and pop while empty are dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign push_ptr_nx = push_ptr + {{ADDR_WIDTH{1'b0}}, do_push};
    assign pop_ptr_nx = pop_ptr + {{ADDR_WIDTH{1'b0}}, do_pop};

    // wrap bit makes the difference exact from 0 up to DEPTH
    assign count_nx = push_ptr_nx - pop_ptr_nx;

    always_ff @(posedge clk) begin
        if (rst) begin
            push_ptr <= '0;
            pop_ptr <= '0;
        end else begin
            push_ptr <= push_ptr_nx;
            pop_ptr <= pop_ptr_nx;
        end
    end

    // flags follow the count they will describe next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            full <= 1'b0;
            full_a <= 1'b0;
            empty <= 1'b1;
            empty_a <= 1'b1;
        end else begin
            count <= count_nx;
            full <= (count_nx == DEPTH);
            full_a <= (count_nx >= DEPTH_A);
            empty <= (count_nx == '0);
            empty_a <= (count_nx <= ONE);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[push_ptr[ADDR_WIDTH-1:0]] <= push_data;
        end
    end

    // registered read, word shows up the cycle after the pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            pop_data <= mem[pop_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // full and empty exclude each other
    a_not_full_and_empty: assert property (
        @(posedge clk) disable iff (rst)
        !(full && empty)
    );

    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= DEPTH
    );

    // full and empty are only reached through their almost flags
    a_full_via_almost: assert property (
        @(posedge clk) disable iff (rst)
        $rose(full) |-> $past(full_a)
    );

    a_empty_via_almost: assert property (
        @(posedge clk) disable iff (rst)
        $rose(empty) |-> $past(empty_a)
    );

endmodule

`default_nettype wire

// ==== logic/ingress_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module ingress_port import merge_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // producer side, four-phase
    input  logic  in_req,
    input  word_t in_data,
    output logic  in_ack,

    // merger side
    input  logic  pop,
    output word_t data,
    output logic  empty
);

    logic full;
    logic push;

    // new request not yet acknowledged and room in the FIFO
    assign push = in_req && !in_ack && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (push) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            // return to zero once the producer lets go
            in_ack <= 1'b0;
        end
    end

    // count and almost flags are only checked inside the FIFO
    fifo_simple #(
        .DATA_WIDTH (WORD_WIDTH),
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (in_data),
        .pop       (pop),
        .pop_data  (data),
        .empty     (empty),
        .full      (full),
        .empty_a   (),
        .full_a    (),
        .count     ()
    );

    // ack only answers a request that is still up
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        (!in_req && !in_ack) |=> !in_ack
    );

endmodule

`default_nettype wire

// ==== logic/rr_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_merger import merge_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // channel 0 FIFO
    input  logic  empty0,
    input  word_t data0,
    output logic  pop0,

    // channel 1 FIFO
    input  logic  empty1,
    input  word_t data1,
    output logic  pop1,

    // consumer side, four-phase
    output logic  out_req,
    output word_t out_data,
    output chan_t out_chan,
    input  logic  out_ack
);

    merge_state_t state;

    // channel served by the most recent pop
    chan_t last_chan;

    logic take;
    logic pick1;

    // channel 1 goes when channel 0 is dry, or on a tie after channel 0
    assign pick1 = !empty1 && (empty0 || last_chan == 1'b0);
    assign take = (state == IDLE) && !(empty0 && empty1);

    assign pop0 = take && !pick1;
    assign pop1 = take && pick1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            // so that channel 0 takes the first tie
            last_chan <= 1'b1;
            out_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        last_chan <= pick1;
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    out_req <= 1'b1;
                    state <= OFFER;
                end
                OFFER: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!out_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // pop_data of the chosen FIFO is valid during LOAD
    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            out_data <= last_chan ? data1 : data0;
            out_chan <= last_chan;
        end
    end

    a_one_pop: assert property (
        @(posedge clk) disable iff (rst)
        !(pop0 && pop1)
    );

    // the offer does not change under the consumer
    a_offer_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_req |=> !out_req || ($stable(out_data) && $stable(out_chan))
    );

endmodule

`default_nettype wire

// ==== logic/stream_merge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_merge_top import merge_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  in0_req,
    input  word_t in0_data,
    output logic  in0_ack,

    input  logic  in1_req,
    input  word_t in1_data,
    output logic  in1_ack,

    output logic  out_req,
    output word_t out_data,
    output chan_t out_chan,
    input  logic  out_ack
);

    // FIFO read side of each channel
    logic  empty0;
    word_t data0;
    logic  pop0;

    logic  empty1;
    word_t data1;
    logic  pop1;

    ingress_port u_ingress0 (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in0_req),
        .in_data (in0_data),
        .in_ack  (in0_ack),
        .pop     (pop0),
        .data    (data0),
        .empty   (empty0)
    );

    ingress_port u_ingress1 (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in1_req),
        .in_data (in1_data),
        .in_ack  (in1_ack),
        .pop     (pop1),
        .data    (data1),
        .empty   (empty1)
    );

    rr_merger u_merger (
        .clk      (clk),
        .rst      (rst),
        .empty0   (empty0),
        .data0    (data0),
        .pop0     (pop0),
        .empty1   (empty1),
        .data1    (data1),
        .pop1     (pop1),
        .out_req  (out_req),
        .out_data (out_data),
        .out_chan (out_chan),
        .out_ack  (out_ack)
    );

endmodule

`default_nettype wire

// ==== tests/merge_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module merge_checker import merge_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // output port of the DUT, observed only
    input  logic  out_req,
    input  word_t out_data,
    input  chan_t out_chan,

    // expected words, one per cycle while exp_valid is high
    input  logic  exp_valid,
    input  chan_t exp_chan,
    input  word_t exp_data,

    // high while buffered words must leave in strict alternation
    input  logic  alt_check,

    // pulse at the end of the run to flag leftover words
    input  logic  end_run,

    output int    mismatches,
    output int    other_errors,
    output int    pending
);

    word_t q0[$];
    word_t q1[$];
    logic  req_q;
    word_t want;

    // channel of the previous output word
    chan_t last_out;
    logic  have_last;

    always @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
            have_last <= 1'b0;
            mismatches <= 0;
            other_errors <= 0;
        end else begin
            req_q <= out_req;
            if (exp_valid) begin
                if (exp_chan) q1.push_back(exp_data);
                else q0.push_back(exp_data);
            end
            // a new offer, data is stable while out_req stays high
            if (out_req && !req_q) begin
                if ((out_chan ? q1.size() : q0.size()) == 0) begin
                    $display("output word %h on channel %0d with no word expected",
                             out_data, out_chan);
                    other_errors <= other_errors + 1;
                end else begin
                    want = out_chan ? q1.pop_front() : q0.pop_front();
                    if (want !== out_data) begin
                        $display("Mismatch out_data ch%0d: expected %h actual %h",
                                 out_chan, want, out_data);
                        mismatches <= mismatches + 1;
                    end
                    // round robin never serves one channel twice while the other waits
                    if (alt_check && have_last && out_chan == last_out
                        && (out_chan ? q0.size() : q1.size()) != 0) begin
                        $display("channel %0d served twice while channel %0d had words waiting",
                                 out_chan, !out_chan);
                        other_errors <= other_errors + 1;
                    end
                end
                last_out <= out_chan;
                have_last <= 1'b1;
            end
            pending = q0.size() + q1.size();
            if (end_run && pending != 0) begin
                $display("%0d words never came out (ch0 %0d, ch1 %0d)",
                         pending, q0.size(), q1.size());
                other_errors <= other_errors + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_stream_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stream_merge import merge_pkg::*; ();

    logic  clk;
    logic  rst;
    logic  in0_req;
    word_t in0_data;
    logic  in0_ack;
    logic  in1_req;
    word_t in1_data;
    logic  in1_ack;
    logic  out_req;
    word_t out_data;
    chan_t out_chan;
    logic  out_ack;

    logic  exp_valid;
    chan_t exp_chan;
    word_t exp_data;
    logic  alt_check;
    logic  end_run;
    int    mismatches;
    int    other_errors;
    int    pending;

    // trace contents
    string cmds[$];
    int    arg_a[$];
    int    arg_b[$];

    // per-channel words waiting for their producer
    word_t send_q0[$];
    word_t send_q1[$];
    logic  busy0;
    logic  busy1;
    logic  hold;
    int    tb_errors;
    int    cycles;
    int    limit;
    int    quiet;

    stream_merge_top DUT (
        .clk      (clk),
        .rst      (rst),
        .in0_req  (in0_req),
        .in0_data (in0_data),
        .in0_ack  (in0_ack),
        .in1_req  (in1_req),
        .in1_data (in1_data),
        .in1_ack  (in1_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_chan (out_chan),
        .out_ack  (out_ack)
    );

    merge_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .out_req      (out_req),
        .out_data     (out_data),
        .out_chan     (out_chan),
        .exp_valid    (exp_valid),
        .exp_chan     (exp_chan),
        .exp_data     (exp_data),
        .alt_check    (alt_check),
        .end_run      (end_run),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .pending      (pending)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // one full four-phase transfer on the given channel
    task automatic send_word(input chan_t c, input word_t w);
        if (c) begin
            in1_data = w;
            in1_req = 1'b1;
        end else begin
            in0_data = w;
            in0_req = 1'b1;
        end
        do begin
            @(posedge clk);
            #1;
        end while (!(c ? in1_ack : in0_ack));
        if (c) in1_req = 1'b0;
        else in0_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (c ? in1_ack : in0_ack);
    endtask

    always begin
        @(posedge clk);
        #1;
        if (send_q0.size() > 0) begin
            busy0 = 1'b1;
            send_word(1'b0, send_q0.pop_front());
            busy0 = 1'b0;
        end
    end

    always begin
        @(posedge clk);
        #1;
        if (send_q1.size() > 0) begin
            busy1 = 1'b1;
            send_word(1'b1, send_q1.pop_front());
            busy1 = 1'b0;
        end
    end

    // consumer with a random ack delay, stalled while hold is set
    always begin
        int unsigned delay;
        @(posedge clk);
        #1;
        if (out_req && !out_ack && !hold) begin
            delay = $urandom % 4;
            if (delay > 0) begin
                repeat (delay) @(posedge clk);
                #1;
            end
            out_ack = 1'b1;
        end else if (!out_req && out_ack) begin
            out_ack = 1'b0;
        end
    end

    task automatic read_trace();
        int    fd;
        int    rc;
        int    a;
        int    b;
        string line;
        string cmd;
        fd = $fopen("tests/merge_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/merge_trace.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 0 && line[0] != "#") begin
                a = 0;
                b = 0;
                rc = $sscanf(line, "%s %d %h", cmd, a, b);
                if (rc >= 1) begin
                    cmds.push_back(cmd);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic post_expected(input chan_t c, input word_t w);
        exp_chan = c;
        exp_data = w;
        exp_valid = 1'b1;
        @(posedge clk);
        #1;
        exp_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in0_req = 1'b0;
        in0_data = '0;
        in1_req = 1'b0;
        in1_data = '0;
        out_ack = 1'b0;
        exp_valid = 1'b0;
        exp_chan = 1'b0;
        exp_data = '0;
        alt_check = 1'b0;
        end_run = 1'b0;
        busy0 = 1'b0;
        busy1 = 1'b0;
        hold = 1'b0;
        tb_errors = 0;
        limit = 0;
        quiet = 0;
        void'($urandom(32'h4d927453));

        read_trace();
        limit = 200 + 40 * cmds.size();

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet outputs after reset until the first push
        repeat (6) begin
            @(posedge clk);
            #1;
            if (out_req !== 1'b0 || in0_ack !== 1'b0 || in1_ack !== 1'b0) begin
                $display("Mismatch out_req/in0_ack/in1_ack: expected 0/0/0 actual %h/%h/%h",
                         out_req, in0_ack, in1_ack);
                tb_errors++;
            end
        end

        foreach (cmds[i]) begin
            if (cmds[i] == "P") begin
                // a producer may still be mid-transfer, so ties are not guaranteed
                alt_check = 1'b0;
                post_expected(chan_t'(arg_a[i]), word_t'(arg_b[i]));
                if (arg_a[i] != 0) send_q1.push_back(word_t'(arg_b[i]));
                else send_q0.push_back(word_t'(arg_b[i]));
            end else if (cmds[i] == "H") begin
                hold = 1'b1;
                alt_check = 1'b0;
            end else if (cmds[i] == "R") begin
                // words buffered under hold must now leave alternating
                hold = 1'b0;
                alt_check = 1'b1;
            end else if (cmds[i] == "W") begin
                repeat (arg_a[i]) @(posedge clk);
                #1;
            end else if (cmds[i] == "E") begin
                break;
            end else begin
                $display("unknown trace command %s", cmds[i]);
                tb_errors++;
            end
        end

        // drain producers and the merger, give up once nothing moves
        hold = 1'b0;
        quiet = 0;
        while ((send_q0.size() > 0 || send_q1.size() > 0 || busy0 || busy1
                || pending != 0 || out_req || out_ack) && quiet < 16) begin
            @(posedge clk);
            #1;
            if (send_q0.size() > 0 || send_q1.size() > 0 || busy0 || busy1
                || out_req || out_ack) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        end_run = 1'b1;
        @(posedge clk);
        #1;
        end_run = 1'b0;
        @(posedge clk);
        #1;

        $display("errors: mismatches %0d, other %0d, testbench %0d",
                 mismatches, other_errors, tb_errors);
        if (mismatches == 0 && other_errors == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/merge_trace.txt ====
# P <chan> <hex word> push one word, H hold consumer, R release consumer
# W <n> wait n cycles, E end of trace
P 0 1111
W 20
P 1 2222
W 20
H
P 0 a001
P 0 a002
P 0 a003
P 0 a004
P 1 b001
P 1 b002
P 1 b003
P 1 b004
W 40
R
W 60
H
P 0 c001
P 0 c002
P 0 c003
P 0 c004
P 0 c005
P 0 c006
P 0 c007
P 0 c008
P 0 c009
P 0 c00a
W 60
R
W 80
P 0 d001
P 1 e001
P 1 e002
P 0 d002
P 0 d003
P 1 e003
W 5
P 0 d004
P 1 e004
P 1 e005
P 0 d005
W 40
E

// ==== tb.f ====
logic/merge_pkg.sv
logic/fifo_simple.sv
logic/ingress_port.sv
logic/rr_merger.sv
logic/stream_merge_top.sv
tests/merge_checker.sv
tests/tb_stream_merge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stream merger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_stream_merge -o sim_stream_merge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_stream_merge)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
